// File: src/rgb_capture_config.svh
`ifndef RGB_CAPTURE_CONFIG_SVH
`define RGB_CAPTURE_CONFIG_SVH

// active picture size in pixels, blanking is not counted
`define RGB_IMAGE_WIDTH 40
`define RGB_IMAGE_HEIGHT 48

// how many whole frames fit in the frame RAM
`define RGB_IMAGES_IN_RAM 3

// whole frames stored before the stream side may start reading
`define RGB_FRAMES_BEFORE_STREAM 1

// 13 bits cover 3 frames of 40 x 48 words, 5760 in total
`define RGB_RAM_ADDR_WIDTH 13

// derived sizes used by the capture logic and the RAM
`define RGB_IMAGE_SIZE (`RGB_IMAGE_WIDTH * `RGB_IMAGE_HEIGHT)
`define RGB_RAM_DEPTH (`RGB_IMAGES_IN_RAM * `RGB_IMAGE_SIZE)

// byte offsets of the host registers on the 4 bit AXI4-Lite address
`define RGB_REG_CTRL 4'h0
`define RGB_REG_STATUS 4'h4
`define RGB_REG_FRAMES 4'h8
`define RGB_REG_WADDR 4'hC

`endif

// File: src/rgb_capture_pkg.sv
`default_nettype none
`include "rgb_capture_config.svh"

package rgb_capture_pkg;

    // parallel video input as seen on the pins
    // hsync and vsync are both high while the pixel is in the active area
    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
    } rgb_in_t;

    // one stored pixel, the layout of a frame RAM word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel565_t;

    // write port of the frame RAM
    typedef struct packed {
        logic                           we;
        logic [`RGB_RAM_ADDR_WIDTH-1:0] addr;
        pixel565_t                      data;
    } ram_wr_t;

    // capture state shared by the register block and the stream reader
    // write_addr is the next free word, so it also counts the words stored
    typedef struct packed {
        logic                           stream_ready;
        logic                           ram_full;
        logic [1:0]                     frames_written;
        logic [`RGB_RAM_ADDR_WIDTH-1:0] write_addr;
    } capture_status_t;

    // AXI4-Lite signals driven by the host
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // AXI4-Lite signals driven back by the register block
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_resp_t;

endpackage

`default_nettype wire

// File: src/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module frame_ram
    import rgb_capture_pkg::*;
(
    input  wire                           rgb_clk,
    input  wire ram_wr_t                  ram_wr,
    input  wire                           rd_en,
    input  wire [`RGB_RAM_ADDR_WIDTH-1:0] rd_addr,
    output pixel565_t                     rd_data
);

    localparam int AW = `RGB_RAM_ADDR_WIDTH;
    localparam int DEPTH = `RGB_RAM_DEPTH;

    // all stored frames back to back, one RGB565 word per pixel
    pixel565_t mem [DEPTH];

    always_ff @(posedge rgb_clk) begin
        if (ram_wr.we) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // registered read, data is valid the cycle after rd_en
    // a read and a write to the same word return the old contents
    always_ff @(posedge rgb_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // the capture logic must stop at the end of RAM instead of wrapping
    a_write_in_range: assert property (@(posedge rgb_clk)
        ram_wr.we |-> ram_wr.addr < AW'(DEPTH))
        else $error("frame RAM write beyond depth");

endmodule

`default_nettype wire

// File: src/rgb_logic.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module rgb_logic
    import rgb_capture_pkg::*;
(
    input  wire             rgb_clk,
    input  wire             nrst,
    input  wire rgb_in_t    video,
    input  wire             capture_enable,
    output ram_wr_t         ram_wr,
    output capture_status_t status
);

    localparam int AW = `RGB_RAM_ADDR_WIDTH;
    localparam int IMAGE_SIZE = `RGB_IMAGE_SIZE;
    localparam int PIX_CNT_W = $clog2(IMAGE_SIZE);
    localparam logic [AW-1:0] LAST_ADDR = AW'(`RGB_RAM_DEPTH - 1);
    localparam logic [PIX_CNT_W-1:0] LAST_PIX = PIX_CNT_W'(IMAGE_SIZE - 1);
    localparam logic [1:0] FRAMES_TO_STREAM = 2'(`RGB_FRAMES_BEFORE_STREAM);

    rgb_in_t          video_q;
    logic             vsync_prev;
    logic             vsync_fall;
    logic             active;
    logic             armed;
    logic             wr_fire;
    logic             frame_done;
    logic [PIX_CNT_W-1:0] pix_cnt;
    logic [AW-1:0]    write_addr;
    logic [1:0]       frames_written;
    logic [1:0]       frames_next;
    logic             ram_full;
    logic             stream_ready;
    logic             wr_we;
    logic [AW-1:0]    wr_addr;
    pixel565_t        wr_data;
    pixel565_t        pix565;

    // only the top bits of each colour are kept, the rest is dropped
    assign pix565 = '{red: video_q.rgb[23:19], green: video_q.rgb[15:10],
                      blue: video_q.rgb[7:3]};

    // a pixel counts only while both syncs are high
    assign active = video_q.hsync & video_q.vsync;
    // end of a frame, the point where capture is allowed to arm
    assign vsync_fall = vsync_prev & ~video_q.vsync;

    assign wr_fire = capture_enable & armed & active & ~ram_full;
    assign frame_done = (pix_cnt == LAST_PIX);
    assign frames_next = frames_written + 2'd1;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            video_q        <= '0;
            vsync_prev     <= 1'b0;
            armed          <= 1'b0;
            pix_cnt        <= '0;
            write_addr     <= '0;
            frames_written <= '0;
            ram_full       <= 1'b0;
            stream_ready   <= 1'b0;
            wr_we          <= 1'b0;
        end else begin
            video_q    <= video;
            vsync_prev <= video_q.vsync;
            // the RAM write trails the sampled pixel by one cycle
            wr_we      <= wr_fire;
            if (!capture_enable) begin
                // dropping enable throws away everything captured so far
                armed          <= 1'b0;
                pix_cnt        <= '0;
                write_addr     <= '0;
                frames_written <= '0;
                ram_full       <= 1'b0;
                stream_ready   <= 1'b0;
            end else begin
                // wait for a frame boundary so a partial frame never lands in RAM
                if (vsync_fall) begin
                    armed <= 1'b1;
                end
                if (wr_fire) begin
                    write_addr <= write_addr + 1'b1;
                    if (write_addr == LAST_ADDR) begin
                        ram_full <= 1'b1;
                    end
                    if (frame_done) begin
                        pix_cnt        <= '0;
                        frames_written <= frames_next;
                        // sticky until enable is cleared
                        if (frames_next == FRAMES_TO_STREAM) begin
                            stream_ready <= 1'b1;
                        end
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // address and data are qualified by wr_we
    always_ff @(posedge rgb_clk) begin
        wr_addr <= write_addr;
        wr_data <= pix565;
    end

    assign ram_wr = '{we: wr_we, addr: wr_addr, data: wr_data};
    // a word still sitting on the write port is not in RAM yet, so it is not
    // counted until the write has happened and the reader cannot fetch it early
    assign status = '{stream_ready: stream_ready, ram_full: ram_full,
                      frames_written: frames_written,
                      write_addr: wr_we ? wr_addr : write_addr};

    // the last write goes out in the cycle full rises, nothing may follow it
    a_no_write_after_full: assert property (@(posedge rgb_clk) disable iff (!nrst)
        status.ram_full |=> !ram_wr.we)
        else $error("frame RAM written after ram_full");

    a_stream_ready_sticky: assert property (@(posedge rgb_clk) disable iff (!nrst)
        status.stream_ready && capture_enable |=> status.stream_ready || !capture_enable)
        else $error("stream_ready fell while capture stayed enabled");

endmodule

`default_nettype wire

// File: src/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module axil_regs
    import rgb_capture_pkg::*;
(
    input  wire                  rgb_clk,
    input  wire                  nrst,
    input  wire axil_req_t       axil_req,
    output axil_resp_t           axil_resp,
    input  wire capture_status_t status,
    output logic                 capture_enable
);

    localparam int AW = `RGB_RAM_ADDR_WIDTH;
    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    logic        aw_fire;
    logic        ar_fire;
    logic        wr_ok;
    logic [1:0]  wr_resp;
    logic [1:0]  rd_resp;
    logic [31:0] rd_word;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rvalid;
    logic [1:0]  rresp;
    logic [31:0] rdata;

    // address and data are taken together, and only when the last
    // write response has been collected
    assign aw_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid;
    // one read in flight at a time
    assign ar_fire = axil_req.arvalid & ~rvalid;

    // CTRL is the only writable register
    assign wr_ok = (axil_req.awaddr == `RGB_REG_CTRL);
    assign wr_resp = wr_ok ? RESP_OKAY : RESP_SLVERR;

    // read mux, anything off the map gives zero data and SLVERR
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            `RGB_REG_CTRL: begin
                rd_word = {31'd0, capture_enable};
            end
            `RGB_REG_STATUS: begin
                rd_word = {30'd0, status.ram_full, status.stream_ready};
            end
            `RGB_REG_FRAMES: begin
                rd_word = {30'd0, status.frames_written};
            end
            `RGB_REG_WADDR: begin
                rd_word = {{(32 - AW){1'b0}}, status.write_addr};
            end
            default: begin
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            bvalid         <= 1'b0;
            rvalid         <= 1'b0;
            capture_enable <= 1'b0;
        end else begin
            if (aw_fire) begin
                bvalid <= 1'b1;
                // bit 0 lives in byte lane 0
                if (wr_ok && axil_req.wstrb[0]) begin
                    capture_enable <= axil_req.wdata[0];
                end
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end

            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload, only looked at while the matching valid is high
    always_ff @(posedge rgb_clk) begin
        if (aw_fire) begin
            bresp <= wr_resp;
        end
        if (ar_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    assign axil_resp = '{awready: aw_fire, wready: aw_fire, bresp: bresp,
                         bvalid: bvalid, arready: ar_fire, rdata: rdata,
                         rresp: rresp, rvalid: rvalid};

    // a write response stays up until the host takes it
    a_bvalid_held: assert property (@(posedge rgb_clk) disable iff (!nrst)
        bvalid && !axil_req.bready |=> bvalid)
        else $error("bvalid dropped without bready");

endmodule

`default_nettype wire

// File: src/stream_reader.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module stream_reader
    import rgb_capture_pkg::*;
(
    input  wire                           rgb_clk,
    input  wire                           nrst,
    input  wire capture_status_t          status,
    output logic                          rd_en,
    output logic [`RGB_RAM_ADDR_WIDTH-1:0] rd_addr,
    input  wire pixel565_t                rd_data,
    output pixel565_t                     pix_out,
    output logic                          pix_valid,
    input  wire                           pix_ready
);

    logic      flush;
    logic      pop;
    logic      issue;
    logic      inflight;
    logic      skid_valid;
    pixel565_t skid_data;

    // write_addr only reads zero before the first write or after enable is
    // cleared, in both cases whatever the reader holds is stale
    assign flush = (status.write_addr == '0);
    assign pop = pix_valid & pix_ready;

    // stay behind the writer and only read when the output slot frees up
    // a full skid means a stall is still being absorbed
    assign issue = status.stream_ready & (rd_addr < status.write_addr) & ~skid_valid &
                   (~pix_valid | pix_ready);
    assign rd_en = issue;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            rd_addr    <= '0;
            inflight   <= 1'b0;
            pix_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush) begin
            rd_addr    <= '0;
            inflight   <= 1'b0;
            pix_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            // RAM data shows up one cycle after the read
            inflight <= issue;
            if (issue) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (!pix_valid || pop) begin
                // the skid is older than the read in flight, so it goes first
                if (skid_valid) begin
                    pix_valid  <= 1'b1;
                    skid_valid <= inflight;
                end else begin
                    pix_valid <= inflight;
                end
            end else if (inflight) begin
                // stalled, park the returning word
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge rgb_clk) begin
        if (!pix_valid || pop) begin
            if (skid_valid) begin
                pix_out   <= skid_data;
                skid_data <= rd_data;
            end else begin
                pix_out <= rd_data;
            end
        end else if (inflight) begin
            skid_data <= rd_data;
        end
    end

    a_hold_on_stall: assert property (@(posedge rgb_clk) disable iff (!nrst)
        pix_valid && !pix_ready && !flush |=> pix_valid && $stable(pix_out))
        else $error("pixel changed while the stream was stalled");

endmodule

`default_nettype wire

// File: src/rgb_capture_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module rgb_capture_top
    import rgb_capture_pkg::*;
(
    input  wire            rgb_clk,
    input  wire            nrst,
    input  wire rgb_in_t   video,
    input  wire axil_req_t axil_req,
    output axil_resp_t     axil_resp,
    output pixel565_t      pix_out,
    output logic           pix_valid,
    input  wire            pix_ready
);

    // enable from the host registers to the capture side
    logic                           capture_enable;
    // capture side into the frame RAM
    ram_wr_t                        ram_wr;
    // shared progress of the writer
    capture_status_t                status;
    // read port between the stream reader and the RAM
    logic                           rd_en;
    logic [`RGB_RAM_ADDR_WIDTH-1:0] rd_addr;
    pixel565_t                      rd_data;

    rgb_logic u_rgb_logic (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .video          (video),
        .capture_enable (capture_enable),
        .ram_wr         (ram_wr),
        .status         (status)
    );

    frame_ram u_frame_ram (
        .rgb_clk (rgb_clk),
        .ram_wr  (ram_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axil_regs u_axil_regs (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .axil_req       (axil_req),
        .axil_resp      (axil_resp),
        .status         (status),
        .capture_enable (capture_enable)
    );

    stream_reader u_stream_reader (
        .rgb_clk   (rgb_clk),
        .nrst      (nrst),
        .status    (status),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .pix_out   (pix_out),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_rgb_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "rgb_capture_config.svh"

module tb_rgb_capture
    import rgb_capture_pkg::*;
();

    localparam int W = `RGB_IMAGE_WIDTH;
    localparam int H = `RGB_IMAGE_HEIGHT;
    // 8 blanking pixels per line and 4 blanking lines per frame
    localparam int LINE_LEN = W + 8;
    localparam int FRAME_LINES = H + 4;
    localparam int IMAGE_SIZE = W * H;
    localparam int DEPTH = `RGB_IMAGES_IN_RAM * IMAGE_SIZE;
    localparam int FRAME_NS = LINE_LEN * FRAME_LINES * 10;

    logic       rgb_clk;
    logic       nrst;
    rgb_in_t    video;
    axil_req_t  axil_req;
    axil_resp_t axil_resp;
    pixel565_t  pix_out;
    logic       pix_valid;
    logic       pix_ready;

    integer     seed;
    // pixels the stream still owes, oldest first
    pixel565_t  model_q[$];
    pixel565_t  exp_pix;
    int         model_total;
    int         model_frames;
    int         streamed;
    logic       enable_on;
    logic       model_armed;
    logic       recording;
    logic       stall_on;
    int         frame_pos;
    string      cur_name;
    int         test_errs;
    int         pass_count;
    int         fail_count;
    longint     limit_ns = 0;

    // one entry per line of the cases file
    string      c_name[$];
    int         c_off[$];
    int         c_frames[$];
    int         c_stall[$];
    int         c_ready[$];
    int         c_full[$];
    int         c_count[$];

    rgb_capture_top dut (
        .rgb_clk   (rgb_clk),
        .nrst      (nrst),
        .video     (video),
        .axil_req  (axil_req),
        .axil_resp (axil_resp),
        .pix_out   (pix_out),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready)
    );

    initial rgb_clk = 1'b0;
    always #5 rgb_clk = ~rgb_clk;

    // the top 5, 6 and 5 bits of red, green and blue make one RAM word
    function automatic pixel565_t pack565(input logic [23:0] rgb);
        pixel565_t p;
        p.red = rgb[23:19];
        p.green = rgb[15:10];
        p.blue = rgb[7:3];
        return p;
    endfunction

    // back-pressure is random in stall tests and absent otherwise
    always @(posedge rgb_clk) begin
        #1;
        pix_ready = stall_on ? 1'($random(seed)) : 1'b1;
    end

    // sampled at the falling edge, where valid, ready and data are settled
    always @(negedge rgb_clk) begin
        if (nrst === 1'b1) begin
            if (pix_valid && model_frames < `RGB_FRAMES_BEFORE_STREAM) begin
                $display("%s: pix_valid rose before enough whole frames were captured",
                         cur_name);
                test_errs++;
            end
            if (pix_valid && pix_ready) begin
                if (model_q.size() == 0) begin
                    $display("%s: pixel %h streamed when none was expected", cur_name,
                             pix_out);
                    test_errs++;
                end else begin
                    exp_pix = model_q.pop_front();
                    if (pix_out !== exp_pix) begin
                        $display("Mismatch %s: pixel %0d expected %h, actual %h", cur_name,
                                 streamed, exp_pix, pix_out);
                        test_errs++;
                    end
                end
                streamed++;
            end
        end
    end

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge rgb_clk);
        #1;
        axil_req.awaddr = addr;
        axil_req.wdata = data;
        axil_req.wstrb = 4'hF;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        // address and data are taken in the same cycle
        @(negedge rgb_clk);
        while (!axil_resp.awready) begin
            @(negedge rgb_clk);
        end
        if (!axil_resp.wready) begin
            $display("%s: write data was not taken together with the write address",
                     cur_name);
            test_errs++;
        end
        @(posedge rgb_clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        @(negedge rgb_clk);
        while (!axil_resp.bvalid) begin
            @(negedge rgb_clk);
        end
        resp = axil_resp.bresp;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge rgb_clk);
        #1;
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        @(negedge rgb_clk);
        while (!axil_resp.arready) begin
            @(negedge rgb_clk);
        end
        @(posedge rgb_clk);
        #1;
        axil_req.arvalid = 1'b0;
        @(negedge rgb_clk);
        while (!axil_resp.rvalid) begin
            @(negedge rgb_clk);
        end
        data = axil_resp.rdata;
        resp = axil_resp.rresp;
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp,
                              input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        if (resp != 2'd0) begin
            $display("%s: %s read returned response %0d instead of OKAY", cur_name, what,
                     resp);
            test_errs++;
        end
        if (data != exp) begin
            $display("Mismatch %s: %s expected %0h, actual %0h", cur_name, what, exp, data);
            test_errs++;
        end
    endtask

    // video timing with active lines first and the vsync blanking at the end
    task automatic send_frames(input int count);
        int          f;
        int          ln;
        int          px;
        logic        active;
        logic [23:0] rgb;
        for (f = 0; f < count; f++) begin
            for (ln = 0; ln < FRAME_LINES; ln++) begin
                for (px = 0; px < LINE_LEN; px++) begin
                    @(posedge rgb_clk);
                    #1;
                    active = (ln < H) && (px < W);
                    rgb = active ? 24'($random(seed)) : 24'h0;
                    video = '{rgb: rgb, hsync: (px < W), vsync: (ln < H)};
                    frame_pos = ln * LINE_LEN + px;
                    // only a frame that starts after arming is kept
                    if (ln == 0 && px == 0) begin
                        recording = model_armed;
                    end
                    // vsync falls here and arms the capture once it is enabled
                    if (ln == H && px == 0 && enable_on) begin
                        model_armed = 1'b1;
                    end
                    if (active && recording && model_total < DEPTH) begin
                        model_q.push_back(pack565(rgb));
                        model_total++;
                        if (ln == H - 1 && px == W - 1) begin
                            model_frames++;
                        end
                    end
                end
            end
        end
        @(posedge rgb_clk);
        #1;
        video = '0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s ok", cur_name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", cur_name, test_errs);
        end
    endtask

    task automatic run_case(input int i);
        logic [1:0] resp;
        int         cycles;
        cur_name = c_name[i];
        test_errs = 0;
        model_q.delete();
        model_total = 0;
        model_frames = 0;
        streamed = 0;
        enable_on = 1'b0;
        model_armed = 1'b0;
        recording = 1'b0;
        frame_pos = 0;
        stall_on = (c_stall[i] != 0);
        // CTRL is written the given number of pixel periods into the first frame
        fork
            send_frames(c_frames[i]);
            begin
                wait (frame_pos >= c_off[i]);
                axil_write(`RGB_REG_CTRL, 32'd1, resp);
                enable_on = 1'b1;
            end
        join
        if (resp != 2'd0) begin
            $display("%s: enable write was not accepted with OKAY", cur_name);
            test_errs++;
        end
        cycles = 0;
        while (model_q.size() != 0 && cycles < 4 * DEPTH) begin
            @(negedge rgb_clk);
            cycles++;
        end
        if (model_q.size() != 0) begin
            $display("%s: stream stopped with %0d pixels still owed", cur_name,
                     model_q.size());
            test_errs++;
        end
        // any pixel in this window would be one too many
        repeat (64) @(negedge rgb_clk);
        if (streamed != c_count[i] * IMAGE_SIZE) begin
            $display("Mismatch %s: streamed pixels expected %0d, actual %0d", cur_name,
                     c_count[i] * IMAGE_SIZE, streamed);
            test_errs++;
        end
        expect_reg(`RGB_REG_STATUS, (c_full[i] << 1) | c_ready[i], "STATUS");
        expect_reg(`RGB_REG_FRAMES, c_count[i], "FRAMES");
        expect_reg(`RGB_REG_WADDR, c_count[i] * IMAGE_SIZE, "WADDR");
        axil_write(`RGB_REG_CTRL, 32'd0, resp);
        enable_on = 1'b0;
        model_armed = 1'b0;
        stall_on = 1'b0;
        expect_reg(`RGB_REG_STATUS, 0, "STATUS after clear");
        expect_reg(`RGB_REG_FRAMES, 0, "FRAMES after clear");
        expect_reg(`RGB_REG_WADDR, 0, "WADDR after clear");
        finish_test();
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          total;
        int          off;
        int          frm;
        int          stl;
        int          rdy;
        int          ful;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] data;
        logic [1:0]  resp;
        seed = 29512;
        nrst = 1'b0;
        video = '0;
        axil_req = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        pix_ready = 1'b1;
        stall_on = 1'b0;
        enable_on = 1'b0;
        model_armed = 1'b0;
        recording = 1'b0;
        model_total = 0;
        model_frames = 0;
        streamed = 0;
        frame_pos = 0;
        pass_count = 0;
        fail_count = 0;
        total = 0;
        fd = $fopen("testbench/rgb_capture_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                n = $sscanf(line, "%s %d %d %d %d %d %d", name, off, frm, stl, rdy, ful,
                            cnt);
                if (line.getc(0) != "#" && n == 7) begin
                    c_name.push_back(name);
                    c_off.push_back(off);
                    c_frames.push_back(frm);
                    c_stall.push_back(stl);
                    c_ready.push_back(rdy);
                    c_full.push_back(ful);
                    c_count.push_back(cnt);
                    total += frm;
                end
            end
            $fclose(fd);
        end
        if (c_name.size() == 0) begin
            $display("no test cases could be read from testbench/rgb_capture_cases.txt");
            fail_count++;
        end
        limit_ns = longint'(total) * FRAME_NS * 3 + 200000;
        repeat (4) @(posedge rgb_clk);
        #1;
        nrst = 1'b1;

        // idle registers straight out of reset, plus the error responses
        cur_name = "reset_state";
        test_errs = 0;
        expect_reg(`RGB_REG_CTRL, 0, "CTRL");
        expect_reg(`RGB_REG_STATUS, 0, "STATUS");
        expect_reg(`RGB_REG_FRAMES, 0, "FRAMES");
        expect_reg(`RGB_REG_WADDR, 0, "WADDR");
        axil_read(4'h2, data, resp);
        if (resp != 2'd2 || data != 32'd0) begin
            $display("Mismatch %s: unmapped read expected resp 2 data 0, %s %0d data %0h",
                     cur_name, "actual resp", resp, data);
            test_errs++;
        end
        axil_write(`RGB_REG_STATUS, 32'h3, resp);
        if (resp != 2'd2) begin
            $display("Mismatch %s: read-only write expected resp 2, actual %0d", cur_name, resp);
            test_errs++;
        end
        expect_reg(`RGB_REG_CTRL, 0, "CTRL after read-only write");
        repeat (32) @(negedge rgb_clk);
        finish_test();

        for (int i = 0; i < c_name.size(); i++) begin
            run_case(i);
        end

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rgb_capture_cases.txt
# each line holds name, enable offset in pixel periods into the first frame, frames sent,
# stall flag for pix_ready, expected stream_ready, expected ram_full, expected FRAMES
# the first frame is always cut by the enable, so whole frames are frames sent minus one
# a frame is 48 x 52 pixel periods and its active area ends at offset 2304

# enable lands in the middle of the picture
mid_frame_enable     700  3  0  1  0  2
# enable before the first active pixel still waits for a frame boundary
enable_at_start        0  2  0  1  0  1
# only a partial frame arrives so nothing may reach the stream
partial_only        1500  1  0  0  0  0
# enable just ahead of the vsync fall
late_enable         2200  2  0  1  0  1

# more frames than the RAM holds
fill_ram             300  6  0  1  1  3
# exactly as many whole frames as fit
exact_capacity       400  4  0  1  1  3

# random back-pressure on the stream side
stall_two_frames    1000  3  1  1  0  2
stall_fill            50  5  1  1  1  3

# capture again from address 0 after the previous clear
reenable             200  2  0  1  0  1

// File: filelist.f
+incdir+src
src/rgb_capture_pkg.sv
src/frame_ram.sv
src/rgb_logic.sv
src/axil_regs.sv
src/stream_reader.sv
src/rgb_capture_top.sv
testbench/tb_rgb_capture.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, all output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rgb_capture \
    -f filelist.f -o sim_rgb_capture > sim.log 2>&1 \
    && ./obj_dir/sim_rgb_capture >> sim.log 2>&1 \
    || echo "Result: FAILED" >> sim.log
cat sim.log
# the run counts as failed whenever the fail message shows up in the log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
